// File: hdl/mvu_cfg.svh
// Sizing constants and address map of the matrix-vector unit
// Included by the package and by every block that sizes a port or memory
`ifndef MVU_CFG_SVH
`define MVU_CFG_SVH

// Datapath
`define MVU_N        8      // Vector lanes, one bit-plane word
`define MVU_MAXPREC  4      // Bits per weight or input
`define MVU_BPREC    2      // Precision minus one
`define MVU_MAXROWS  16
`define MVU_BROW     4
`define MVU_BLVL     3      // Combined significance, up to 6
`define MVU_BACC     16     // Signed row sum

// Memory addressing
`define MVU_BWADDR   6      // Row * 4 + weight bit
`define MVU_BDADDR   2      // Input bit
`define MVU_BOADDR   4      // Output row

// Issue to product latency (memory read plus product register)
`define MVU_PIPE     2

// Wishbone word bus
`define MVU_WB_AW    8
`define MVU_WB_DW    32

// Window select sits in the address bits above this one
`define MVU_WIN_LSB  6

`endif

// File: hdl/mvu_pkg.sv
// Bus, configuration and pipeline types of the matrix-vector unit
// Shared by the RTL blocks and the testbench checker
`default_nettype none

`include "mvu_cfg.svh"

package mvu_pkg;

    // Wishbone classic, full words only
    typedef struct packed {
        logic                   cyc;
        logic                   stb;
        logic                   we;
        logic [`MVU_WB_AW-1:0]  adr;
        logic [`MVU_WB_DW-1:0]  dat;
    } wb_req_t;

    typedef struct packed {
        logic                   ack;
        logic [`MVU_WB_DW-1:0]  dat;
    } wb_rsp_t;

    // Precisions and row count are stored minus one
    typedef struct packed {
        logic [`MVU_BPREC-1:0]  wprec;
        logic [`MVU_BPREC-1:0]  iprec;
        logic                   wsigned;
        logic                   isigned;
        logic [`MVU_BROW-1:0]   rows;
    } job_cfg_t;

    typedef struct packed {
        logic                   we_w;   // Weight plane write
        logic                   we_d;   // Input plane write
        logic [`MVU_BWADDR-1:0] addr;
        logic [`MVU_N-1:0]      data;
        logic [`MVU_BOADDR-1:0] oaddr;  // Output read row
    } host_mem_t;

    // One weight/input bit pair as issued by the address generator
    typedef struct packed {
        logic [`MVU_BWADDR-1:0] waddr;
        logic [`MVU_BDADDR-1:0] daddr;
        logic                   sh;
        logic                   neg;
        logic                   row_end;
    } zz_op_t;

    typedef enum logic [1:0] {IDLE, RUN, DRAIN} ctrl_state_t;

    typedef enum logic [`MVU_WIN_LSB-1:0] {
        REG_CTRL   = 0,
        REG_CONFIG = 1,
        REG_STATUS = 2
    } reg_sel_t;

    typedef enum logic [`MVU_WB_AW-`MVU_WIN_LSB-1:0] {
        WIN_REG, WIN_WGT, WIN_INP, WIN_OUT
    } mem_win_t;

endpackage

`default_nettype wire

// File: hdl/mvu_regs.sv
// Wishbone slave of the unit with register file, start pulse and host memory port
// Every access is acked one cycle after it is seen; writes are dropped while busy
`timescale 1ns/10ps
`default_nettype none

`include "mvu_cfg.svh"

module mvu_regs (
    input  logic                   intf,
    input  logic                   reset,
    input  mvu_pkg::wb_req_t       wb_req,
    output mvu_pkg::wb_rsp_t       wb_rsp,
    input  logic                   busy,
    input  logic                   done,
    output mvu_pkg::job_cfg_t      cfg,
    output logic                   start,
    output mvu_pkg::host_mem_t     host_mem,
    input  logic [`MVU_BACC-1:0]   out_word
);

    mvu_pkg::mem_win_t      win;
    mvu_pkg::reg_sel_t      sel;
    mvu_pkg::job_cfg_t      cfg_q;
    logic                   act;
    logic                   blk;
    logic                   wr_ok;
    logic                   ack_q;
    logic                   go_q;          // Start written, waiting for ack
    logic                   out_sel_q;     // Acked read came from output window
    logic                   we_w_q;
    logic                   we_d_q;
    logic [`MVU_BWADDR-1:0] mem_addr_q;
    logic [`MVU_N-1:0]      mem_data_q;
    logic [`MVU_WB_DW-1:0]  rd_data;
    logic [`MVU_WB_DW-1:0]  rd_q;

    assign win = mvu_pkg::mem_win_t'(wb_req.adr[`MVU_WB_AW-1:`MVU_WIN_LSB]);
    assign sel = mvu_pkg::reg_sel_t'(wb_req.adr[`MVU_WIN_LSB-1:0]);

    // Request still held during its ack cycle, so skip that one
    assign act   = wb_req.cyc & wb_req.stb & ~ack_q;
    assign blk   = busy | start;       // Job running or about to
    assign wr_ok = act & wb_req.we & ~blk;

    always_comb begin
        rd_data = '0;
        if (win == mvu_pkg::WIN_REG) begin
            case (sel)
                mvu_pkg::REG_CONFIG: rd_data = `MVU_WB_DW'(cfg_q);
                mvu_pkg::REG_STATUS: rd_data = {{(`MVU_WB_DW-2){1'b0}}, done, busy};
                default:             rd_data = '0;
            endcase
        end
    end

    always_ff @(posedge intf) begin
        if (reset) begin
            ack_q     <= 1'b0;
            go_q      <= 1'b0;
            start     <= 1'b0;
            out_sel_q <= 1'b0;
            we_w_q    <= 1'b0;
            we_d_q    <= 1'b0;
            cfg_q     <= '0;
        end else begin
            ack_q  <= act;
            go_q   <= wr_ok && win == mvu_pkg::WIN_REG && sel == mvu_pkg::REG_CTRL
                      && wb_req.dat[0];
            start  <= go_q;            // Lands the cycle after ack
            we_w_q <= wr_ok && win == mvu_pkg::WIN_WGT;
            we_d_q <= wr_ok && win == mvu_pkg::WIN_INP;
            if (act) begin
                out_sel_q <= win == mvu_pkg::WIN_OUT;
            end
            if (wr_ok && win == mvu_pkg::WIN_REG && sel == mvu_pkg::REG_CONFIG) begin
                cfg_q <= mvu_pkg::job_cfg_t'(wb_req.dat[$bits(mvu_pkg::job_cfg_t)-1:0]);
            end
        end
    end

    // Write payload and register read data
    always_ff @(posedge intf) begin
        if (act) begin
            mem_addr_q <= wb_req.adr[`MVU_BWADDR-1:0];
            mem_data_q <= wb_req.dat[`MVU_N-1:0];
            rd_q       <= rd_data;
        end
    end

    assign cfg = cfg_q;

    always_comb begin
        host_mem.we_w  = we_w_q;
        host_mem.we_d  = we_d_q;
        host_mem.addr  = mem_addr_q;
        host_mem.data  = mem_data_q;
        host_mem.oaddr = wb_req.adr[`MVU_BOADDR-1:0];   // Core registers the read
    end

    assign wb_rsp.ack = ack_q;
    assign wb_rsp.dat = out_sel_q
                      ? {{(`MVU_WB_DW-`MVU_BACC){out_word[`MVU_BACC-1]}}, out_word}
                      : rd_q;

    // Master keeps the access up through its ack, so the masked cycle is the same access
    a_ack_held: assert property (@(posedge intf) disable iff (reset)
        ack_q |-> wb_req.cyc && wb_req.stb);

endmodule

`default_nettype wire

// File: hdl/mvu_controller.sv
// Job state machine of the unit
// Runs from start until the last pair is issued, drains the pipeline, then flags done
`timescale 1ns/10ps
`default_nettype none

`include "mvu_cfg.svh"

module mvu_controller (
    input  logic intf,
    input  logic reset,
    input  logic start,
    input  logic issue_last,
    output logic busy,
    output logic done,
    output logic irq
);

    localparam int DW = $clog2(`MVU_PIPE + 1);

    mvu_pkg::ctrl_state_t state_q;
    logic [DW-1:0]        cnt_q;       // Drain cycles elapsed
    logic                 drain_end;

    assign drain_end = (state_q == mvu_pkg::DRAIN) && (cnt_q == DW'(`MVU_PIPE));

    always_ff @(posedge intf) begin
        if (reset) begin
            state_q <= mvu_pkg::IDLE;
            cnt_q   <= '0;
            done    <= 1'b0;
            irq     <= 1'b0;
        end else begin
            irq <= drain_end;          // Same edge that raises done
            case (state_q)
                mvu_pkg::IDLE: begin
                    if (start) begin
                        state_q <= mvu_pkg::RUN;
                        done    <= 1'b0;
                    end
                end
                mvu_pkg::RUN: begin
                    if (issue_last) begin
                        state_q <= mvu_pkg::DRAIN;
                        cnt_q   <= '0;
                    end
                end
                mvu_pkg::DRAIN: begin
                    if (drain_end) begin
                        state_q <= mvu_pkg::IDLE;
                        done    <= 1'b1;   // Sticky until next start
                    end else begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                end
                default: state_q <= mvu_pkg::IDLE;
            endcase
        end
    end

    assign busy = state_q != mvu_pkg::IDLE;

    // The register block holds start back while a job is active
    a_start_idle: assert property (@(posedge intf) disable iff (reset)
        start |-> state_q == mvu_pkg::IDLE);

endmodule

`default_nettype wire

// File: hdl/mvu_agu.sv
// Zig-zag address generator over weight and input bit-planes
// Per row, walks combined significance downward, one bit pair per cycle
`timescale 1ns/10ps
`default_nettype none

`include "mvu_cfg.svh"

module mvu_agu (
    input  logic              intf,
    input  logic              reset,
    input  logic              start,
    input  mvu_pkg::job_cfg_t cfg,
    output logic              issue_valid,
    output mvu_pkg::zz_op_t   op,
    output logic              issue_last
);

    logic                   run_q;
    logic [`MVU_BPREC-1:0]  wp_q;
    logic [`MVU_BPREC-1:0]  ip_q;
    logic                   ws_q;
    logic                   is_q;
    logic [`MVU_BROW-1:0]   rows_q;
    logic [`MVU_BROW-1:0]   row_q;
    logic [`MVU_BLVL-1:0]   lvl_q;     // wbit + ibit of current pair
    logic [`MVU_BPREC-1:0]  wb_q;
    logic [`MVU_BLVL-1:0]   top;
    logic [`MVU_BPREC-1:0]  ib;
    logic [`MVU_BPREC-1:0]  wb_lo;
    logic                   lvl_end;
    logic                   row_done;

    // Highest weight bit that exists at a given level
    function automatic logic [`MVU_BPREC-1:0] hi_of(input logic [`MVU_BLVL-1:0]  lvl,
                                                    input logic [`MVU_BPREC-1:0] wp);
        hi_of = (lvl > `MVU_BLVL'(wp)) ? wp : lvl[`MVU_BPREC-1:0];
    endfunction

    assign top      = `MVU_BLVL'(wp_q) + `MVU_BLVL'(ip_q);
    assign ib       = `MVU_BPREC'(lvl_q - `MVU_BLVL'(wb_q));
    assign wb_lo    = (lvl_q > `MVU_BLVL'(ip_q)) ? `MVU_BPREC'(lvl_q - `MVU_BLVL'(ip_q)) : '0;
    assign lvl_end  = wb_q == wb_lo;
    assign row_done = lvl_end && lvl_q == '0;

    always_ff @(posedge intf) begin
        if (reset) begin
            run_q  <= 1'b0;
            wp_q   <= '0;
            ip_q   <= '0;
            ws_q   <= 1'b0;
            is_q   <= 1'b0;
            rows_q <= '0;
            row_q  <= '0;
            lvl_q  <= '0;
            wb_q   <= '0;
        end else if (start) begin
            run_q  <= 1'b1;
            wp_q   <= cfg.wprec;
            ip_q   <= cfg.iprec;
            ws_q   <= cfg.wsigned;
            is_q   <= cfg.isigned;
            rows_q <= cfg.rows;
            row_q  <= '0;
            lvl_q  <= `MVU_BLVL'(cfg.wprec) + `MVU_BLVL'(cfg.iprec);
            wb_q   <= cfg.wprec;
        end else if (run_q) begin
            if (!lvl_end) begin
                wb_q <= wb_q - 1'b1;
            end else if (lvl_q != '0) begin
                lvl_q <= lvl_q - 1'b1;
                wb_q  <= hi_of(lvl_q - 1'b1, wp_q);
            end else begin
                if (row_q == rows_q) begin
                    run_q <= 1'b0;     // Last row issued
                end
                row_q <= row_q + 1'b1;
                lvl_q <= top;
                wb_q  <= wp_q;
            end
        end
    end

    assign issue_valid = run_q;
    assign issue_last  = run_q && row_done && row_q == rows_q;

    always_comb begin
        op.waddr   = {row_q, wb_q};
        op.daddr   = ib;
        op.sh      = (wb_q == hi_of(lvl_q, wp_q)) && (lvl_q != top);  // Entering a lower level
        op.neg     = (ws_q && wb_q == wp_q) ^ (is_q && ib == ip_q);   // One signed MSB
        op.row_end = row_done;
    end

endmodule

`default_nettype wire

// File: hdl/mvu_core.sv
// Datapath of the unit: bit-plane memories, AND-popcount and shift-accumulator
// Ops from the address generator are consumed MVU_PIPE cycles after issue
`timescale 1ns/10ps
`default_nettype none

`include "mvu_cfg.svh"

module mvu_core (
    input  logic                 intf,
    input  logic                 reset,
    input  logic                 issue_valid,
    input  mvu_pkg::zz_op_t      op,
    input  mvu_pkg::host_mem_t   host_mem,
    output logic [`MVU_BACC-1:0] out_word
);

    localparam int BCNT = $clog2(`MVU_N + 1);

    logic [`MVU_N-1:0]           wmem [`MVU_MAXROWS*`MVU_MAXPREC];
    logic [`MVU_N-1:0]           dmem [`MVU_MAXPREC];
    logic [`MVU_BACC-1:0]        omem [`MVU_MAXROWS];
    logic [`MVU_N-1:0]           wrd_q;
    logic [`MVU_N-1:0]           drd_q;
    logic [BCNT-1:0]             cnt_q;
    mvu_pkg::zz_op_t             op_dly [`MVU_PIPE];
    logic [`MVU_PIPE-1:0]        vld_dly;
    mvu_pkg::zz_op_t             cur;
    logic                        cur_vld;
    logic                        first_q;  // Next pair opens a row
    logic [`MVU_BOADDR-1:0]      orow_q;
    logic signed [`MVU_BACC-1:0] acc_q;
    logic signed [`MVU_BACC-1:0] term;
    logic signed [`MVU_BACC-1:0] base;
    logic signed [`MVU_BACC-1:0] acc_sum;
    logic                        out_we;

    function automatic logic [BCNT-1:0] popcnt(input logic [`MVU_N-1:0] v);
        logic [BCNT-1:0] c;
        c = '0;
        for (int i = 0; i < `MVU_N; i++) begin
            c = c + BCNT'(v[i]);
        end
        return c;
    endfunction

    // Host side of the memories
    always_ff @(posedge intf) begin
        if (host_mem.we_w) begin
            wmem[host_mem.addr] <= host_mem.data;
        end
        if (host_mem.we_d) begin
            dmem[host_mem.addr[`MVU_BDADDR-1:0]] <= host_mem.data;
        end
        out_word <= omem[host_mem.oaddr];
    end

    // Plane read, then product register
    always_ff @(posedge intf) begin
        wrd_q <= wmem[op.waddr];
        drd_q <= dmem[op.daddr];
        cnt_q <= popcnt(wrd_q & drd_q);
    end

    // Flag delay line matched to the two stages above
    always_ff @(posedge intf) begin
        op_dly[0] <= op;
        for (int i = 1; i < `MVU_PIPE; i++) begin
            op_dly[i] <= op_dly[i-1];
        end
    end

    always_ff @(posedge intf) begin
        if (reset) begin
            vld_dly <= '0;
        end else begin
            vld_dly <= {vld_dly[`MVU_PIPE-2:0], issue_valid};
        end
    end

    assign cur     = op_dly[`MVU_PIPE-1];
    assign cur_vld = vld_dly[`MVU_PIPE-1];

    assign term    = `MVU_BACC'(cnt_q);
    assign base    = first_q ? '0 : (cur.sh ? acc_q <<< 1 : acc_q);
    assign acc_sum = base + (cur.neg ? -term : term);
    assign out_we  = cur_vld && cur.row_end;

    // Row counter rests at zero whenever the pipeline is empty between jobs
    always_ff @(posedge intf) begin
        if (reset) begin
            first_q <= 1'b1;
            orow_q  <= '0;
        end else begin
            first_q <= !cur_vld || cur.row_end;
            if (!cur_vld) begin
                orow_q <= '0;
            end else if (cur.row_end) begin
                orow_q <= orow_q + 1'b1;
            end
        end
    end

    always_ff @(posedge intf) begin
        if (cur_vld) begin
            acc_q <= acc_sum;
        end
        if (out_we) begin
            omem[orow_q] <= acc_sum;   // Row sum including its last pair
        end
    end

    // Written row matches the row the generator issued, so it stays within the job
    a_orow_match: assert property (@(posedge intf) disable iff (reset)
        out_we |-> orow_q == cur.waddr[`MVU_BWADDR-1 -: `MVU_BROW]);

endmodule

`default_nettype wire

// File: hdl/mvu_top.sv
// Top level of the bit-serial matrix-vector unit
// Wishbone slave in, irq out; connects registers, controller, address generator and core
`timescale 1ns/10ps
`default_nettype none

`include "mvu_cfg.svh"

module mvu_top (
    input  logic             intf,
    input  logic             reset,
    input  mvu_pkg::wb_req_t wb_req,
    output mvu_pkg::wb_rsp_t wb_rsp,
    output logic             irq
);

    mvu_pkg::job_cfg_t    cfg;
    mvu_pkg::host_mem_t   host_mem;
    mvu_pkg::zz_op_t      op;
    logic                 start;
    logic                 busy;
    logic                 done;
    logic                 issue_valid;
    logic                 issue_last;
    logic [`MVU_BACC-1:0] out_word;

    mvu_regs regs (
        .intf     (intf),
        .reset    (reset),
        .wb_req   (wb_req),
        .wb_rsp   (wb_rsp),
        .busy     (busy),
        .done     (done),
        .cfg      (cfg),
        .start    (start),
        .host_mem (host_mem),
        .out_word (out_word)
    );

    mvu_controller ctrl (
        .intf       (intf),
        .reset      (reset),
        .start      (start),
        .issue_last (issue_last),
        .busy       (busy),
        .done       (done),
        .irq        (irq)
    );

    mvu_agu agu (
        .intf        (intf),
        .reset       (reset),
        .start       (start),
        .cfg         (cfg),
        .issue_valid (issue_valid),
        .op          (op),
        .issue_last  (issue_last)
    );

    mvu_core core (
        .intf        (intf),
        .reset       (reset),
        .issue_valid (issue_valid),
        .op          (op),
        .host_mem    (host_mem),
        .out_word    (out_word)
    );

endmodule

`default_nettype wire

// File: verif/mvu_checker.sv
// Bus monitor of the matrix-vector unit with a reference model of its jobs
// Snoops accepted writes, checks every acked read and the irq pulse of each job
`timescale 1ns/10ps
`default_nettype none

`include "mvu_cfg.svh"

module mvu_checker (
    input  logic             intf,
    input  logic             reset,
    input  mvu_pkg::wb_req_t wb_req,
    input  mvu_pkg::wb_rsp_t wb_rsp,
    input  logic             irq,
    input  logic             end_run,
    output int               errors,
    output int               reads
);

    logic [`MVU_N-1:0]    wmod [`MVU_MAXROWS*`MVU_MAXPREC];
    logic [`MVU_N-1:0]    dmod [`MVU_MAXPREC];
    logic [`MVU_BACC-1:0] exp_out [`MVU_MAXROWS];
    mvu_pkg::job_cfg_t    cfg_m;
    mvu_pkg::job_cfg_t    job_m;      // Config latched at start
    logic                 active;     // Job running, writes dropped
    logic                 done_m;
    logic                 ack_d;
    logic                 closed;
    int                   jobs;
    int                   irqs;       // Pulses seen in current job

    // Sum over all bit pairs of popcount(w & x) weighted by 2^(wbit+ibit)
    function automatic logic [`MVU_BACC-1:0] row_sum(input int r);
        int   acc;
        int   pc;
        logic neg;
        acc = 0;
        for (int wb = 0; wb <= int'(job_m.wprec); wb++) begin
            for (int ib = 0; ib <= int'(job_m.iprec); ib++) begin
                pc  = $countones(wmod[r * `MVU_MAXPREC + wb] & dmod[ib]);
                neg = (job_m.wsigned && wb == int'(job_m.wprec))
                    ^ (job_m.isigned && ib == int'(job_m.iprec));   // One signed MSB
                acc = neg ? acc - (pc << (wb + ib)) : acc + (pc << (wb + ib));
            end
        end
        return `MVU_BACC'(acc);
    endfunction

    task automatic report(input string msg);
        errors++;
        $display("%s", msg);
    endtask

    task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] got);
        reads++;
        if (exp !== got) begin
            errors++;
            $display("error: %s expected %h actual %h", name, exp, got);
        end
    endtask

    task automatic start_job();
        if (jobs > 0 && irqs != 1) begin
            report($sformatf("Job %0d ended with %0d irq pulses instead of one", jobs, irqs));
        end
        jobs++;
        irqs   = 0;
        active = 1'b1;
        done_m = 1'b0;
        job_m  = cfg_m;
        for (int r = 0; r <= int'(job_m.rows); r++) begin
            exp_out[r] = row_sum(r);
        end
    endtask

    task automatic snoop_write(input logic [7:0] adr, input logic [31:0] dat);
        if (!active) begin
            case (mvu_pkg::mem_win_t'(adr[7:`MVU_WIN_LSB]))
                mvu_pkg::WIN_REG: begin
                    if (adr[5:0] == 6'd1) begin
                        cfg_m = mvu_pkg::job_cfg_t'(dat[$bits(mvu_pkg::job_cfg_t)-1:0]);
                    end else if (adr[5:0] == 6'd0 && dat[0]) begin
                        start_job();
                    end
                end
                mvu_pkg::WIN_WGT: wmod[adr[5:0]] = dat[`MVU_N-1:0];
                mvu_pkg::WIN_INP: dmod[adr[1:0]] = dat[`MVU_N-1:0];
                default: ;
            endcase
        end
    endtask

    task automatic check_read(input logic [7:0] adr, input logic [31:0] got);
        logic [`MVU_BOADDR-1:0] row;
        row = adr[`MVU_BOADDR-1:0];
        case (mvu_pkg::mem_win_t'(adr[7:`MVU_WIN_LSB]))
            mvu_pkg::WIN_REG: begin
                if (adr[5:0] == 6'd1) begin
                    compare("wb_rsp.dat (REG_CONFIG)", 32'(cfg_m), got);
                end else if (adr[5:0] == 6'd2) begin
                    compare("wb_rsp.dat (REG_STATUS)",
                            active ? 32'd1 : {30'd0, done_m, 1'b0}, got);
                end else begin
                    compare("wb_rsp.dat (unmapped register)", 32'd0, got);
                end
            end
            mvu_pkg::WIN_OUT: begin
                if (jobs > 0 && row <= job_m.rows) begin   // Rows of the last job only
                    compare($sformatf("wb_rsp.dat (output row %0d)", row),
                            {{(32-`MVU_BACC){exp_out[row][`MVU_BACC-1]}}, exp_out[row]}, got);
                end
            end
            default: ;
        endcase
    endtask

    always @(posedge intf) begin
        if (reset) begin
            active = 1'b0;
            done_m = 1'b0;
            ack_d  = 1'b0;
            closed = 1'b0;
            cfg_m  = '0;
            jobs   = 0;
            irqs   = 0;
            errors = 0;
            reads  = 0;
        end else begin
            if (wb_rsp.ack && ack_d) begin
                report("Ack stayed high for two cycles");
            end
            if (wb_rsp.ack && !(wb_req.cyc && wb_req.stb)) begin
                report("Ack came with no request pending");
            end
            if (wb_rsp.ack) begin
                if (wb_req.we) begin
                    snoop_write(wb_req.adr, wb_req.dat);
                end else begin
                    check_read(wb_req.adr, wb_rsp.dat);
                end
            end
            // After the bus, since an access acked here was seen while busy
            if (irq) begin
                if (!active) begin
                    report("Irq pulse with no job running");
                end else begin
                    active = 1'b0;
                    done_m = 1'b1;
                    irqs++;
                end
            end
            ack_d = wb_rsp.ack;
            if (end_run && !closed) begin
                closed = 1'b1;
                if (active) begin
                    report("Last job never finished");
                end else if (jobs > 0 && irqs != 1) begin
                    report($sformatf("Job %0d ended with %0d irq pulses instead of one",
                                     jobs, irqs));
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: verif/mvu_tb.sv
// Testbench of the matrix-vector unit
// Runs a table of jobs over the Wishbone port; the checker module judges every read
`timescale 1ns/10ps
`default_nettype none

`include "mvu_cfg.svh"

module mvu_tb;

    typedef struct packed {
        mvu_pkg::job_cfg_t cfg;
        logic [1:0]        status;    // Expected status after the job
    } job_t;

    localparam int NJOBS = 8;
    localparam int LIMIT = NJOBS * 2000;   // Watchdog, in cycles

    logic             intf;
    logic             reset;
    mvu_pkg::wb_req_t wb_req;
    mvu_pkg::wb_rsp_t wb_rsp;
    logic             irq;
    logic             end_run;
    int               chk_errors;
    int               chk_reads;
    int               bus_errors;
    job_t             jobs_tab [NJOBS];
    logic [31:0]      rd;

    mvu_top uut (
        .intf   (intf),
        .reset  (reset),
        .wb_req (wb_req),
        .wb_rsp (wb_rsp),
        .irq    (irq)
    );

    mvu_checker chk (
        .intf    (intf),
        .reset   (reset),
        .wb_req  (wb_req),
        .wb_rsp  (wb_rsp),
        .irq     (irq),
        .end_run (end_run),
        .errors  (chk_errors),
        .reads   (chk_reads)
    );

    always #5 intf = ~intf;

    // Table holds bit counts and row count, the register wants them minus one
    function automatic job_t make_job(input int wp, input int ip, input logic wsgn,
                                      input logic isgn, input int rows);
        job_t j;
        j.cfg.wprec   = `MVU_BPREC'(wp - 1);
        j.cfg.iprec   = `MVU_BPREC'(ip - 1);
        j.cfg.wsigned = wsgn;
        j.cfg.isigned = isgn;
        j.cfg.rows    = `MVU_BROW'(rows - 1);
        j.status      = 2'b10;            // Done, not busy
        return j;
    endfunction

    function automatic logic [`MVU_WB_AW-1:0] addr_of(input mvu_pkg::mem_win_t win,
                                                      input int idx);
        return {win, `MVU_WIN_LSB'(idx)};
    endfunction

    // One full-word access; request held until ack
    task automatic bus_access(input logic we, input logic [`MVU_WB_AW-1:0] adr,
                              input logic [31:0] dat, output logic [31:0] rdata);
        int waits;
        waits = 0;
        @(posedge intf);
        wb_req.cyc <= 1'b1;
        wb_req.stb <= 1'b1;
        wb_req.we  <= we;
        wb_req.adr <= adr;
        wb_req.dat <= dat;
        do begin
            @(posedge intf);
            waits++;
        end while (!wb_rsp.ack && waits < 16);
        if (!wb_rsp.ack) begin
            bus_errors++;
            $display("No ack for the access to address %h", adr);
        end
        rdata = wb_rsp.dat;
        wb_req.cyc <= 1'b0;
        wb_req.stb <= 1'b0;
        wb_req.we  <= 1'b0;
    endtask

    task automatic bus_write(input logic [`MVU_WB_AW-1:0] adr, input logic [31:0] dat);
        logic [31:0] unused;
        bus_access(1'b1, adr, dat, unused);
    endtask

    task automatic bus_read(input logic [`MVU_WB_AW-1:0] adr, output logic [31:0] rdata);
        bus_access(1'b0, adr, 32'd0, rdata);
    endtask

    task automatic run_job(input job_t j);
        logic [31:0] st;
        for (int r = 0; r <= int'(j.cfg.rows); r++) begin
            for (int b = 0; b <= int'(j.cfg.wprec); b++) begin
                bus_write(addr_of(mvu_pkg::WIN_WGT, r * `MVU_MAXPREC + b),
                          {24'd0, 8'($urandom)});
            end
        end
        for (int b = 0; b <= int'(j.cfg.iprec); b++) begin
            bus_write(addr_of(mvu_pkg::WIN_INP, b), {24'd0, 8'($urandom)});
        end
        bus_write(addr_of(mvu_pkg::WIN_REG, int'(mvu_pkg::REG_CONFIG)), 32'(j.cfg));
        bus_write(addr_of(mvu_pkg::WIN_REG, int'(mvu_pkg::REG_CTRL)), 32'd1);
        bus_write(addr_of(mvu_pkg::WIN_WGT, 0), {24'd0, 8'($urandom)});  // Lands while busy
        do begin
            bus_read(addr_of(mvu_pkg::WIN_REG, int'(mvu_pkg::REG_STATUS)), st);
        end while (st[1:0] != j.status);
        bus_read(addr_of(mvu_pkg::WIN_REG, int'(mvu_pkg::REG_CONFIG)), st);
        for (int r = 0; r <= int'(j.cfg.rows); r++) begin
            bus_read(addr_of(mvu_pkg::WIN_OUT, r), st);
        end
        bus_read(addr_of(mvu_pkg::WIN_REG, int'(mvu_pkg::REG_STATUS)), st);  // Done held
    endtask

    initial begin : watchdog
        repeat (LIMIT) @(posedge intf);
        $display("Timeout after %0d cycles, the run did not finish", LIMIT);
        $display("Checks failed");
        $finish;
    end

    initial begin : main
        void'($urandom(10));
        intf       = 1'b0;
        reset      = 1'b1;
        wb_req     = '0;
        end_run    = 1'b0;
        bus_errors = 0;
        jobs_tab[0] = make_job(1, 1, 1'b0, 1'b0, 4);     // Unsigned precisions
        jobs_tab[1] = make_job(2, 2, 1'b0, 1'b0, 6);
        jobs_tab[2] = make_job(4, 4, 1'b0, 1'b0, 8);
        jobs_tab[3] = make_job(4, 2, 1'b1, 1'b0, 5);     // Signed weights
        jobs_tab[4] = make_job(2, 4, 1'b0, 1'b1, 5);     // Signed inputs
        jobs_tab[5] = make_job(4, 4, 1'b1, 1'b1, 16);
        jobs_tab[6] = make_job(3, 1, 1'b1, 1'b0, 3);
        jobs_tab[7] = make_job(1, 3, 1'b1, 1'b1, 16);
        repeat (2) @(posedge intf);
        reset <= 1'b0;
        bus_read(addr_of(mvu_pkg::WIN_REG, int'(mvu_pkg::REG_STATUS)), rd);  // Idle after reset
        for (int i = 0; i < NJOBS; i++) begin
            run_job(jobs_tab[i]);
        end
        @(posedge intf);
        end_run <= 1'b1;
        repeat (3) @(posedge intf);
        $display("Summary: %0d checker errors, %0d bus errors, %0d reads compared",
                 chk_errors, bus_errors, chk_reads);
        if (chk_errors == 0 && bus_errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
+incdir+hdl
hdl/mvu_pkg.sv
hdl/mvu_regs.sv
hdl/mvu_controller.sv
hdl/mvu_agu.sv
hdl/mvu_core.sv
hdl/mvu_top.sv
verif/mvu_checker.sv
verif/mvu_tb.sv

// File: Makefile
# Verilator build and run of the matrix-vector unit testbench

TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = mvu_tb
FILELIST = build.f
OBJDIR   = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	@grep -q "All checks passed" $(LOG) || (echo "Simulation did not pass"; exit 1)

clean:
	rm -rf $(OBJDIR) $(LOG)
